//--- include/squash_config.svh
// Size settings for the squash arbitration unit
// Included by the package and by every module that sizes a sequence number

`ifndef SQUASH_CONFIG_SVH
`define SQUASH_CONFIG_SVH

// --------------------
// Sequence numbers
// --------------------

// Width of one sequence number
// The age space is 2**SQUASH_SEQ_NUM_BITS entries, so it must exceed
// the number of instructions in flight
`define SQUASH_SEQ_NUM_BITS 5

// --------------------
// Squash sources
// --------------------

// Squash producers feeding the unit
// Branch redirect, memory ordering and exception by default, plus one spare
// Any value of 1 or more works, padding covers non-power-of-two counts
`define SQUASH_NUM_ARB 4

`endif

//--- source/squash_pkg.sv
// Shared types of the squash arbitration unit
// Notification structs and the grant register state
// Compile before any module of the unit

`default_nettype none

`include "squash_config.svh"

package squash_pkg;

  // --------------------
  // Notifications
  // --------------------

  // One squash request from a pipeline source
  // Field order matches the bus used across the core
  typedef struct packed {
    logic [`SQUASH_SEQ_NUM_BITS-1:0] seq_num;
    logic                     [31:0] target;
    logic                            val;
  } squash_notif_t;

  // One retired instruction
  // Only val drives the head tracker
  // The rest rides along on the shared commit bus
  typedef struct packed {
    logic [31:0] pc;
    logic  [4:0] waddr;
    logic [31:0] wdata;
    logic        wen;
    logic        val;
  } commit_notif_t;

  // --------------------
  // Grant register
  // --------------------

  // Output state of the arbitration tree
  // GNT_SQUASH holds a granted squash for one cycle
  typedef enum logic {
    GNT_IDLE   = 1'b0,
    GNT_SQUASH = 1'b1
  } grant_state_e;

endpackage

`default_nettype wire

//--- source/seq_age.sv
// Head tracker for relative age compares
// Counts valid commits to follow the oldest uncommitted sequence number
// The head feeds every age comparator of the squash tree

`timescale 1ns/1ps
`default_nettype none

`include "squash_config.svh"

module seq_age (
  input  logic                            clk,
  input  logic                            reset,

  // --------------------
  // Commit stream
  // --------------------

  input  squash_pkg::commit_notif_t       commit,

  // --------------------
  // Oldest uncommitted instruction
  // --------------------

  output logic [`SQUASH_SEQ_NUM_BITS-1:0] head
);

  // Registered head pointer
  logic [`SQUASH_SEQ_NUM_BITS-1:0] head_q;
  logic [`SQUASH_SEQ_NUM_BITS-1:0] head_next;

  // --------------------
  // Next head
  // --------------------

  // One step per retired instruction
  // Natural overflow gives the modulo wrap of the sequence space
  always_comb begin
    head_next = head_q;
    if (commit.val) begin
      head_next = head_q + 1'b1;
    end
  end

  // --------------------
  // Head register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      // Sequence numbering starts at 0
      head_q <= '0;
    end else begin
      head_q <= head_next;
    end
  end

  // Consumers see the value from before this edge's commit
  assign head = head_q;

  // --------------------
  // Checks
  // --------------------

  // An unknown commit valid would corrupt every later age compare
  commit_val_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(commit.val)
  ) else $error("commit.val is unknown outside reset");

endmodule

`default_nettype wire

//--- source/squash_pair_arb.sv
// Two-input age comparator for the squash tree
// Passes the older valid notification, relative to the head
// Purely combinational, one instance per internal tree node

`timescale 1ns/1ps
`default_nettype none

`include "squash_config.svh"

module squash_pair_arb (
  // Oldest uncommitted sequence number
  input  logic [`SQUASH_SEQ_NUM_BITS-1:0] head,

  // --------------------
  // Candidates
  // --------------------

  // arb0 always carries the lower source index
  input  squash_pkg::squash_notif_t       arb0,
  input  squash_pkg::squash_notif_t       arb1,

  // --------------------
  // Winner
  // --------------------

  output squash_pkg::squash_notif_t       gnt
);

  // Distance from the head, wrapping in the sequence space
  logic [`SQUASH_SEQ_NUM_BITS-1:0] age0;
  logic [`SQUASH_SEQ_NUM_BITS-1:0] age1;

  assign age0 = arb0.seq_num - head;
  assign age1 = arb1.seq_num - head;

  always_comb begin
    if (!arb0.val) begin
      // Only arb1 can be valid
      // If it is not, its low val bit carries through
      gnt = arb1;
    end else if (!arb1.val) begin
      gnt = arb0;
    end else if (age1 < age0) begin
      // Strictly older upper input
      gnt = arb1;
    end else begin
      // Ties keep the lower index
      gnt = arb0;
    end
  end

endmodule

`default_nettype wire

//--- source/squash_arb_tree.sv
// Binary tree of age comparators with a registered grant
// Picks the oldest valid squash out of num_arb sources
// Grant appears one cycle after the inputs are sampled

`timescale 1ns/1ps
`default_nettype none

`include "squash_config.svh"

module squash_arb_tree #(
  parameter int unsigned num_arb = `SQUASH_NUM_ARB
) (
  input  logic                                    clk,
  input  logic                                    reset,

  // Oldest uncommitted sequence number
  input  logic      [`SQUASH_SEQ_NUM_BITS-1:0]    head,

  // --------------------
  // Squash sources
  // --------------------

  input  squash_pkg::squash_notif_t [num_arb-1:0] arb,

  // --------------------
  // Registered winner
  // --------------------

  output squash_pkg::squash_notif_t               gnt
);

  import squash_pkg::*;

  // Leaves padded up to a power of two
  localparam int unsigned num_levels = $clog2(num_arb);
  localparam int unsigned num_pad    = 1 << num_levels;

  // Heap layout
  // Node n has children 2n and 2n+1, root at 1, leaf i at num_pad+i
  // A single source makes the leaf and the root the same node
  squash_notif_t nodes [1:2*num_pad-1];

  // --------------------
  // Leaves
  // --------------------

  for (genvar i = 0; i < num_pad; i++) begin : g_leaf
    if (i < num_arb) begin : g_src
      assign nodes[num_pad+i] = arb[i];
    end else begin : g_pad
      // Padding never wins
      assign nodes[num_pad+i] = '0;
    end
  end

  // --------------------
  // Comparator nodes
  // --------------------

  // Even child holds the lower indices, so it goes to arb0
  // That keeps the lower-index tie rule across all levels
  for (genvar n = 1; n < num_pad; n++) begin : g_node
    squash_pair_arb u_pair (
      .head (head),
      .arb0 (nodes[2*n]),
      .arb1 (nodes[2*n+1]),
      .gnt  (nodes[n])
    );
  end

  // --------------------
  // Output register
  // --------------------

  grant_state_e                    gnt_state;
  logic [`SQUASH_SEQ_NUM_BITS-1:0] gnt_seq_num_q;
  logic                     [31:0] gnt_target_q;

  // Valid state, reset to idle
  // A fresh decision every cycle, no hold beyond one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      gnt_state <= GNT_IDLE;
    end else if (nodes[1].val) begin
      gnt_state <= GNT_SQUASH;
    end else begin
      gnt_state <= GNT_IDLE;
    end
  end

  // Payload only matters while in GNT_SQUASH
  always_ff @(posedge clk) begin
    gnt_seq_num_q <= nodes[1].seq_num;
    gnt_target_q  <= nodes[1].target;
  end

  assign gnt.seq_num = gnt_seq_num_q;
  assign gnt.target  = gnt_target_q;
  assign gnt.val     = (gnt_state == GNT_SQUASH);

  // --------------------
  // Checks
  // --------------------

  // Any source valid this cycle
  logic any_val;

  always_comb begin
    any_val = 1'b0;
    for (int i = 0; i < num_arb; i++) begin
      any_val = any_val | arb[i].val;
    end
  end

  // No grant without a request one edge earlier
  gnt_needs_request: assert property (
    @(posedge clk) disable iff (reset)
    gnt.val |-> $past(any_val)
  ) else $error("grant without a valid source at the previous edge");

  // Reset leaves the output idle
  gnt_idle_after_reset: assert property (
    @(posedge clk)
    $past(reset) |-> !gnt.val
  ) else $error("grant valid in the cycle after reset");

endmodule

`default_nettype wire

//--- source/squash_unit.sv
// Squash arbitration unit, top level
// Forwards the oldest of several same-cycle squash notifications
// Age is relative to the head, tracked from the commit stream
// One cycle from squash inputs to gnt, no back-pressure

`timescale 1ns/1ps
`default_nettype none

`include "squash_config.svh"

module squash_unit (
  input  logic                                            clk,
  input  logic                                            reset,

  // --------------------
  // Squash sources
  // --------------------

  // Branch redirect, memory ordering, exception and so on
  // Present whenever val is high, never acknowledged
  input  squash_pkg::squash_notif_t [`SQUASH_NUM_ARB-1:0] arb,

  // --------------------
  // Commit stream
  // --------------------

  // Each valid commit retires the head instruction
  input  squash_pkg::commit_notif_t                       commit,

  // --------------------
  // Oldest squash
  // --------------------

  // Registered, held for exactly one cycle
  output squash_pkg::squash_notif_t                       gnt
);

  // Oldest uncommitted sequence number
  // Shared by every comparator in the tree
  logic [`SQUASH_SEQ_NUM_BITS-1:0] head;

  // --------------------
  // Head tracker
  // --------------------

  // A commit on the sampling edge only moves the head afterwards
  seq_age u_seq_age (
    .clk    (clk),
    .reset  (reset),
    .commit (commit),
    .head   (head)
  );

  // --------------------
  // Arbitration tree
  // --------------------

  // Lower source index wins on equal age
  squash_arb_tree #(
    .num_arb (`SQUASH_NUM_ARB)
  ) u_arb_tree (
    .clk   (clk),
    .reset (reset),
    .head  (head),
    .arb   (arb),
    .gnt   (gnt)
  );

endmodule

`default_nettype wire

//--- testbench/tb_squash_unit.sv
// Directed and random testbench for the squash arbitration unit
// A reference model tracks the head and predicts the oldest squash
// Every driven cycle is checked one edge later against the model

`timescale 1ns/1ps
`default_nettype none

`include "squash_config.svh"

module tb_squash_unit;

  import squash_pkg::*;

  localparam int num_src    = `SQUASH_NUM_ARB;
  localparam int seq_bits   = `SQUASH_SEQ_NUM_BITS;
  localparam int seq_space  = 1 << seq_bits;
  // Reset, directed tests and 2000 random cycles stay near 2100 cycles
  localparam int max_cycles = 3000;

  logic                              clk;
  logic                              reset;
  squash_notif_t [num_src-1:0]       arb;
  commit_notif_t                     commit;
  squash_notif_t                     gnt;

  // Model and bookkeeping
  logic [seq_bits-1:0] model_head  = '0;
  logic         [31:0] rng_state   = 32'd52393;
  int                  cycle_count = 0;

  squash_unit u_dut (
    .clk    (clk),
    .reset  (reset),
    .arb    (arb),
    .commit (commit),
    .gnt    (gnt)
  );

  // --------------------
  // Clock and timeout
  // --------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Run timed out after %0d cycles before the tests finished", cycle_count);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // Helpers
  // --------------------

  // 32-bit xorshift
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic squash_notif_t make_notif(input int seq, input logic [31:0] target);
    squash_notif_t n;
    n.seq_num = seq[seq_bits-1:0];
    n.target  = target;
    n.val     = 1'b1;
    return n;
  endfunction

  // Linear scan where the smallest relative age wins
  // Strict compare keeps the lowest index on ties
  function automatic squash_notif_t oldest_valid(input squash_notif_t [num_src-1:0] srcs,
                                                 input logic [seq_bits-1:0] head_ref);
    squash_notif_t       best;
    logic [seq_bits-1:0] best_age;
    logic [seq_bits-1:0] age;
    best     = '0;
    best_age = '0;
    for (int i = 0; i < num_src; i++) begin
      age = srcs[i].seq_num - head_ref;
      if (srcs[i].val && (!best.val || age < best_age)) begin
        best     = srcs[i];
        best_age = age;
      end
    end
    return best;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected 0x%0h got 0x%0h", name, expected, actual);
      $display("Errors found");
      $fatal(1, "check of %s failed", name);
    end
  endtask

  // Called 1 ns after an edge
  // Drives one cycle, waits for the sampling edge, checks the grant
  task automatic drive_cycle(input squash_notif_t [num_src-1:0] srcs,
                             input logic commit_val, input logic [31:0] commit_pc);
    squash_notif_t expected;
    arb        = srcs;
    commit     = '0;
    commit.val = commit_val;
    commit.pc  = commit_pc;
    // Compare uses the head from before this edge's commit
    expected = oldest_valid(srcs, model_head);
    @(posedge clk);
    #1;
    if (commit_val) begin
      model_head = model_head + 1'b1;
    end
    check_value("gnt.val", expected.val, gnt.val);
    if (expected.val) begin
      check_value("gnt.seq_num", expected.seq_num, gnt.seq_num);
      check_value("gnt.target", expected.target, gnt.target);
    end
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task automatic test_idle_after_reset();
    check_value("gnt.val", 1'b0, gnt.val);
    repeat (6) drive_cycle('0, 1'b0, 32'h0);
  endtask

  // Each source alone and then the drop
  task automatic test_single_sources();
    squash_notif_t [num_src-1:0] srcs;
    for (int i = 0; i < num_src; i++) begin
      srcs    = '0;
      srcs[i] = make_notif(i * 7 + 2, 32'h8000_0000 + i * 32'h0001_1111);
      drive_cycle(srcs, 1'b0, 32'h0);
      check_value("gnt.seq_num", srcs[i].seq_num, gnt.seq_num);
      check_value("gnt.target", srcs[i].target, gnt.target);
      drive_cycle('0, 1'b0, 32'h0);
      check_value("gnt.val", 1'b0, gnt.val);
    end
  endtask

  // Head still at 0 here
  task automatic test_priority();
    squash_notif_t [num_src-1:0] srcs;
    // Distinct numbers with source 1 the smallest
    srcs[0] = make_notif(7, 32'h0000_1000);
    srcs[1] = make_notif(3, 32'h0000_1100);
    srcs[2] = make_notif(9, 32'h0000_1200);
    srcs[3] = make_notif(5, 32'h0000_1300);
    drive_cycle(srcs, 1'b0, 32'h0);
    check_value("gnt.seq_num", 3, gnt.seq_num);
    check_value("gnt.target", 32'h0000_1100, gnt.target);
    // All equal so source 0 wins
    for (int i = 0; i < num_src; i++) begin
      srcs[i] = make_notif(4, 32'h0000_2000 + i);
    end
    drive_cycle(srcs, 1'b0, 32'h0);
    check_value("gnt.target", 32'h0000_2000, gnt.target);
    // Tie between 1 and 2 across subtrees
    srcs[0] = make_notif(6, 32'h0000_3000);
    srcs[1] = make_notif(2, 32'h0000_3100);
    srcs[2] = make_notif(2, 32'h0000_3200);
    srcs[3] = make_notif(8, 32'h0000_3300);
    drive_cycle(srcs, 1'b0, 32'h0);
    check_value("gnt.target", 32'h0000_3100, gnt.target);
    drive_cycle('0, 1'b0, 32'h0);
  endtask

  // Move head two below the top of the space
  task automatic test_wrap_around();
    squash_notif_t [num_src-1:0] srcs;
    while (model_head != seq_space - 2) begin
      drive_cycle('0, 1'b1, 32'h0000_4000 + model_head);
    end
    // Ages 3, 1, 2, 0 relative to the head
    srcs[0] = make_notif(1, 32'h0000_5000);
    srcs[1] = make_notif(seq_space - 1, 32'h0000_5100);
    srcs[2] = make_notif(0, 32'h0000_5200);
    srcs[3] = make_notif(seq_space - 2, 32'h0000_5300);
    drive_cycle(srcs, 1'b0, 32'h0);
    check_value("gnt.target", 32'h0000_5300, gnt.target);
    // Numerically larger but older
    srcs    = '0;
    srcs[0] = make_notif(1, 32'h0000_6000);
    srcs[1] = make_notif(seq_space - 1, 32'h0000_6100);
    drive_cycle(srcs, 1'b0, 32'h0);
    check_value("gnt.seq_num", seq_space - 1, gnt.seq_num);
    drive_cycle('0, 1'b0, 32'h0);
  endtask

  // Commit at the sampling edge only shifts the next compare
  task automatic test_commit_same_cycle();
    squash_notif_t [num_src-1:0] srcs;
    int                          h;
    h       = model_head;
    srcs    = '0;
    srcs[0] = make_notif(h, 32'h0000_7000);
    srcs[1] = make_notif(h + 1, 32'h0000_7100);
    drive_cycle(srcs, 1'b1, 32'h0000_7777);
    check_value("gnt.target", 32'h0000_7000, gnt.target);
    // Source 0 is now the youngest
    drive_cycle(srcs, 1'b0, 32'h0);
    check_value("gnt.target", 32'h0000_7100, gnt.target);
    drive_cycle('0, 1'b0, 32'h0);
  endtask

  task automatic test_random(input int num_cycles);
    squash_notif_t [num_src-1:0] srcs;
    logic                 [31:0] rnd;
    logic                        commit_val;
    for (int c = 0; c < num_cycles; c++) begin
      for (int i = 0; i < num_src; i++) begin
        rnd             = next_random();
        srcs[i].val     = rnd[0];
        srcs[i].seq_num = rnd[8 +: seq_bits];
        srcs[i].target  = next_random();
      end
      rnd        = next_random();
      commit_val = rnd[3];
      drive_cycle(srcs, commit_val, next_random());
    end
  endtask

  // --------------------
  // Sequence
  // --------------------

  initial begin
    reset  = 1'b1;
    arb    = '0;
    commit = '0;
    repeat (10) @(posedge clk);
    #1;
    reset      = 1'b0;
    model_head = '0;

    test_idle_after_reset();
    test_single_sources();
    test_priority();
    test_wrap_around();
    test_commit_same_cycle();
    test_random(2000);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
source/squash_pkg.sv
source/seq_age.sv
source/squash_pair_arb.sv
source/squash_arb_tree.sv
source/squash_unit.sv
testbench/tb_squash_unit.sv
